// File: dv/fetch_tb.sv
/*
   Testbench for the fetch stage top level
   LCG program and stimulus, cycle-level reference model,
   output compare task and cycle-count timeout
*/
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

   // Program fills the memory during the reset window, one word per cycle
   localparam int unsigned reset_cycles = 16;
   localparam int unsigned prog_len     = reset_cycles;
   localparam int unsigned tail_cycles  = 8;
   localparam int unsigned cycle_limit  =
      prog_len * (ctrl_shadow + raw_depth + 2) + dump_delay + tail_cycles + 64;
   // Halt sits one word before the end
   localparam logic [word_w-1:0] halt_pc = word_w'(2 * (prog_len - 2));

   logic               clk;
   logic               rst_n;
   logic               prog_we;
   logic [imem_aw-1:0] prog_addr;
   logic [word_w-1:0]  prog_data;
   logic               pc_src;
   logic [word_w-1:0]  jump_pc;
   logic [reg_w-1:0]   dst;
   logic               dst_valid;
   logic [word_w-1:0]  instr_out;
   logic [word_w-1:0]  incr_pc;
   logic               dump;

   logic [31:0]        lcg_state = 32'h15cb;
   logic [word_w-1:0]  prog [prog_len];
   int unsigned        cycle_cnt = 0;
   int unsigned        tail;

   // Reference model state
   logic [word_w-1:0]  m_pc;
   int unsigned        m_shadow;
   logic               m_halted;
   int unsigned        m_age;
   logic [reg_w-1:0]   m_hist_dst [raw_depth];
   logic               m_hist_v [raw_depth];
   logic [word_w-1:0]  m_instr;
   logic [word_w-1:0]  m_incr;
   logic               m_dump;

   fetch_top fetch_top_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .prog_we   (prog_we),
      .prog_addr (prog_addr),
      .prog_data (prog_data),
      .pc_src    (pc_src),
      .jump_pc   (jump_pc),
      .dst       (dst),
      .dst_valid (dst_valid),
      .instr_out (instr_out),
      .incr_pc   (incr_pc),
      .dump      (dump)
   );

   // 4 ns clock
   always #2 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   // LCG, upper half of the state is the better random source
   function automatic int unsigned next_rand(input int unsigned range);
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return (lcg_state >> 16) % range;
   endfunction

   task automatic check_value(input string what, input logic [word_w-1:0] got,
                              input logic [word_w-1:0] exp);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "output mismatch");
      end
   endtask

   // Mostly ALU words, a few jumps, branches and nops, halt near the end
   task automatic build_program();
      int unsigned       pick;
      logic [2:0]        top;
      logic [10:0]       operands;
      for (int i = 0; i < prog_len; i++) begin
         pick     = next_rand(16);
         operands = 11'(next_rand(2048));
         top      = 3'(next_rand(8));
         // ALU groups only, so remap the 000 group and the control classes
         if (top == 3'b000 || top == jump_class || top == branch_class) begin
            top = 3'b111;
         end
         if (i == prog_len - 2) begin
            prog[i] = {op_halt, operands};
         end else if (pick < 10) begin
            prog[i] = {top, 2'(next_rand(4)), operands};
         end else if (pick < 12) begin
            prog[i] = {jump_class, 2'(next_rand(4)), operands};
         end else if (pick < 14) begin
            prog[i] = {branch_class, 2'(next_rand(4)), operands};
         end else begin
            prog[i] = {op_nop, operands};
         end
      end
   endtask

   // Random destinations, rare forward redirects that never pass the halt
   task automatic drive_inputs();
      int unsigned step;
      dst_valid = (next_rand(4) == 0);
      dst       = 3'(next_rand(8));
      pc_src    = (next_rand(12) == 0);
      step      = next_rand(3);
      jump_pc   = m_pc + word_w'(2 * step);
      if (jump_pc > halt_pc) begin
         jump_pc = halt_pc;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   // Live destination or any valid history entry
   function automatic logic in_flight(input logic [reg_w-1:0] src);
      int unsigned hits;
      hits = (dst_valid && dst == src) ? 1 : 0;
      for (int i = 0; i < raw_depth; i++) begin
         if (m_hist_v[i] && m_hist_dst[i] == src) begin
            hits++;
         end
      end
      return hits != 0;
   endfunction

   task automatic model_reset();
      m_pc     = '0;
      m_shadow = 0;
      m_halted = 1'b0;
      m_age    = 0;
      m_instr  = nop_word;
      m_incr   = '0;
      m_dump   = 1'b0;
      for (int i = 0; i < raw_depth; i++) begin
         m_hist_dst[i] = '0;
         m_hist_v[i]   = 1'b0;
      end
   endtask

   // One clock edge, from the state and the inputs of the current cycle
   task automatic model_step();
      logic [word_w-1:0] word;
      logic              rs_ok;
      logic              rt_ok;
      logic              hazard;
      logic              bubble;
      logic              ctrl;
      logic              halt_now;
      word   = prog[int'(m_pc >> 1)];
      // Source fields rs at 10:8, rt at 7:5
      rs_ok  = !(word[15:13] == 3'b000 || {word[15:13], word[11]} == 4'b0010);
      rt_ok  = (word[15:12] == 4'b1101) || (word[15:13] == 3'b111);
      hazard = (rs_ok && in_flight(word[10:8])) || (rt_ok && in_flight(word[7:5]));
      bubble = hazard || (m_shadow != 0) || m_halted;
      ctrl   = !bubble && (word[15:13] == jump_class || word[15:13] == branch_class);
      halt_now = !bubble && (word[15:11] == op_halt);

      // Pipe outputs
      m_instr = bubble ? nop_word : word;
      m_incr  = m_pc + word_w'(2);

      // PC, halt freeze first, then redirect, then hold
      if (!(m_halted || halt_now)) begin
         if (pc_src) begin
            m_pc = jump_pc;
         end else if (!(bubble || ctrl)) begin
            m_pc = m_pc + word_w'(2);
         end
      end

      // Control shadow
      if (pc_src) begin
         m_shadow = 0;
      end else if (ctrl) begin
         m_shadow = ctrl_shadow;
      end else if (m_shadow != 0) begin
         m_shadow--;
      end

      // Halt latch and dump delay
      if (m_halted) begin
         if (m_age < dump_delay) begin
            m_age++;
         end
      end else if (halt_now) begin
         m_halted = 1'b1;
         m_age    = 0;
      end
      m_dump = m_halted && (m_age >= dump_delay);

      // History shift, newest at 0
      for (int i = raw_depth - 1; i > 0; i--) begin
         m_hist_dst[i] = m_hist_dst[i-1];
         m_hist_v[i]   = m_hist_v[i-1];
      end
      m_hist_dst[0] = dst;
      m_hist_v[0]   = dst_valid;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      pc_src    = 1'b0;
      jump_pc   = '0;
      dst       = '0;
      dst_valid = 1'b0;
      model_reset();
      build_program();

      // Load during reset, word 0 is written on the first edge
      prog_we   = 1'b1;
      prog_addr = '0;
      prog_data = prog[0];
      for (int i = 1; i < prog_len; i++) begin
         @(posedge clk);
         #1;
         prog_addr = imem_aw'(i);
         prog_data = prog[i];
      end
      @(posedge clk);
      #1;
      prog_we = 1'b0;
      rst_n   = 1'b1;
      drive_inputs();

      // Outputs are compared mid-cycle, model advances after the compare
      tail = 0;
      while (tail < tail_cycles) begin
         @(negedge clk);
         check_value("instr_out", instr_out, m_instr);
         check_value("incr_pc", incr_pc, m_incr);
         check_value("dump", {15'b0, dump}, {15'b0, m_dump});
         if (m_dump) begin
            tail++;
         end
         model_step();
         @(posedge clk);
         #1;
         drive_inputs();
      end
      $display("RESULT: PASS");
      $finish;
   end

   // Run limit, counted from reset release
   always @(posedge clk) begin
      if (rst_n) begin
         cycle_cnt = cycle_cnt + 1;
         if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: dump not seen within %0d cycles after reset", cycle_limit);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
         end
      end
   end

endmodule

// File: logic/fetch.sv
/*
   Fetch control
   Bubble select, control shadow, halt latch and dump delay
   Output pipe registers toward decode
*/
`timescale 1ns/1ps

module fetch import fetch_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   // Word at the current PC and its sequential successor
   input  logic [word_w-1:0] instr,
   input  logic [word_w-1:0] pc_next_seq,
   // Hazard and class flags for instr
   input  logic              raw,
   input  logic              is_halt,
   input  logic              is_jump,
   input  logic              is_branch,
   // Redirect strobe from execute
   input  logic              pc_src,
   output logic              pc_hold,
   // Pipe outputs
   output logic [word_w-1:0] instr_out,
   output logic [word_w-1:0] incr_pc,
   output logic              dump
);

   logic [shadow_w-1:0]   shadow_cnt;
   logic                  halted;
   logic [dump_delay-1:0] dump_sr;

   logic stall;
   logic ctrl_issue;
   logic halt_issue;
   logic freeze;

   ////////////////////////////////////////////////////////////////////////////
   // Issue decision
   ////////////////////////////////////////////////////////////////////////////

   // Bubble on RAW, inside a control shadow, or once halted
   assign stall = raw || (shadow_cnt != '0) || halted;

   // Words that actually leave the stage
   assign ctrl_issue = (is_jump || is_branch) && !stall;
   assign halt_issue = is_halt && !stall;

   // Halt freeze is permanent and beats any redirect
   assign freeze = halted || halt_issue;

   // Hold while stalling or on the jump itself
   // A redirect releases the hold so the PC can take jump_pc
   assign pc_hold = freeze || ((stall || ctrl_issue) && !pc_src);

   ////////////////////////////////////////////////////////////////////////////
   // Control shadow
   ////////////////////////////////////////////////////////////////////////////

   // Loaded by an issuing jump or branch, counts down one bubble per cycle
   // Redirect ends the shadow early
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         shadow_cnt <= '0;
      end else if (pc_src) begin
         shadow_cnt <= '0;
      end else if (ctrl_issue) begin
         shadow_cnt <= shadow_w'(ctrl_shadow);
      end else if (shadow_cnt != '0) begin
         shadow_cnt <= shadow_cnt - 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Halt and dump
   ////////////////////////////////////////////////////////////////////////////

   // Sticky until reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         halted <= 1'b0;
      end else if (halt_issue) begin
         halted <= 1'b1;
      end
   end

   // Delay line behind the halt latch, dump_delay edges after the halt issues
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dump_sr <= '0;
      end else begin
         dump_sr <= {dump_sr[dump_delay-2:0], halted};
      end
   end

   assign dump = dump_sr[dump_delay-1];

   ////////////////////////////////////////////////////////////////////////////
   // Pipe registers
   ////////////////////////////////////////////////////////////////////////////

   // Come out of reset as a bubble
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         instr_out <= nop_word;
         incr_pc   <= '0;
      end else begin
         instr_out <= stall ? nop_word : instr;
         incr_pc   <= pc_next_seq;
      end
   end

   // Counter stays within the shadow length
   a_shadow_bound: assert property (
      @(posedge clk) disable iff (!rst_n) shadow_cnt <= shadow_w'(ctrl_shadow)
   ) else $error("fetch: shadow counter out of range (%0d)", shadow_cnt);

   // Dump is a level, it only drops with reset
   a_dump_sticky: assert property (
      @(posedge clk) disable iff (!rst_n) dump |=> dump
   ) else $error("fetch: dump fell without reset");

endmodule

// File: logic/fetch_pkg.sv
/*
   Shared constants for the fetch stage
   Widths, opcode classes, NOP and HALT encodings, stall depths
*/
package fetch_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////////////////////

   // Instruction word and PC
   localparam int unsigned word_w  = 16;
   // Register file index
   localparam int unsigned reg_w   = 3;
   // 256 words, indexed by PC[8:1]
   localparam int unsigned imem_aw = 8;

   ////////////////////////////////////////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////////////////////////////////////////

   localparam logic [4:0] op_halt = 5'b00000;
   localparam logic [4:0] op_nop  = 5'b00001;

   // Bubble is a NOP with all operand fields zero
   localparam logic [word_w-1:0] nop_word = {op_nop, 11'b0};

   // Opcode class in the top three bits
   localparam logic [2:0] jump_class   = 3'b001;
   localparam logic [2:0] branch_class = 3'b011;

   ////////////////////////////////////////////////////////////////////////////
   // Stall depths
   ////////////////////////////////////////////////////////////////////////////

   // In-flight destinations kept by the RAW detector
   localparam int unsigned raw_depth   = 3;
   // Bubbles behind a jump or branch
   localparam int unsigned ctrl_shadow = 2;
   // Halt fetch to dump
   localparam int unsigned dump_delay  = 5;

   // Shadow counter width, wide enough to hold ctrl_shadow
   localparam int unsigned shadow_w = $clog2(ctrl_shadow + 1);

endpackage

// File: logic/fetch_top.sv
/*
   Fetch stage top level
   Memory, PC unit, classifier, RAW detector and fetch control
*/
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
   input  logic               clk,
   input  logic               rst_n,
   // Program load, used during reset
   input  logic               prog_we,
   input  logic [imem_aw-1:0] prog_addr,
   input  logic [word_w-1:0]  prog_data,
   // Redirect from execute
   input  logic               pc_src,
   input  logic [word_w-1:0]  jump_pc,
   // Destination accepted downstream
   input  logic [reg_w-1:0]   dst,
   input  logic               dst_valid,
   // Toward decode
   output logic [word_w-1:0]  instr_out,
   output logic [word_w-1:0]  incr_pc,
   output logic               dump
);

   logic [word_w-1:0] pc;
   logic [word_w-1:0] pc_next_seq;
   logic              pc_hold;
   logic [word_w-1:0] instr;
   logic [reg_w-1:0]  rs;
   logic [reg_w-1:0]  rt;
   logic              rs_valid;
   logic              rt_valid;
   logic              is_halt;
   logic              is_jump;
   logic              is_branch;
   logic              raw;

   // Word index is PC[8:1]
   instr_mem instr_mem_i (
      .clk   (clk),
      .addr  (pc[imem_aw:1]),
      .rdata (instr),
      .we    (prog_we),
      .waddr (prog_addr),
      .wdata (prog_data)
   );

   pc_unit pc_unit_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .pc_src      (pc_src),
      .jump_pc     (jump_pc),
      .pc_hold     (pc_hold),
      .pc          (pc),
      .pc_next_seq (pc_next_seq)
   );

   instr_classify instr_classify_i (
      .instr     (instr),
      .rs        (rs),
      .rt        (rt),
      .rs_valid  (rs_valid),
      .rt_valid  (rt_valid),
      .is_halt   (is_halt),
      .is_jump   (is_jump),
      .is_branch (is_branch)
   );

   raw_detector raw_detector_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .rs        (rs),
      .rt        (rt),
      .rs_valid  (rs_valid),
      .rt_valid  (rt_valid),
      .dst       (dst),
      .dst_valid (dst_valid),
      .raw       (raw)
   );

   fetch fetch_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr       (instr),
      .pc_next_seq (pc_next_seq),
      .raw         (raw),
      .is_halt     (is_halt),
      .is_jump     (is_jump),
      .is_branch   (is_branch),
      .pc_src      (pc_src),
      .pc_hold     (pc_hold),
      .instr_out   (instr_out),
      .incr_pc     (incr_pc),
      .dump        (dump)
   );

endmodule

// File: logic/instr_classify.sv
/*
   Instruction classifier
   Source fields, their validity and the halt / jump / branch class
*/
`timescale 1ns/1ps

module instr_classify import fetch_pkg::*; (
   input  logic [word_w-1:0] instr,
   // Source register fields
   output logic [reg_w-1:0]  rs,
   output logic [reg_w-1:0]  rt,
   output logic              rs_valid,
   output logic              rt_valid,
   // Class flags
   output logic              is_halt,
   output logic              is_jump,
   output logic              is_branch
);

   logic [4:0] opcode;

   assign opcode = instr[15:11];

   ////////////////////////////////////////////////////////////////////////////
   // Sources
   ////////////////////////////////////////////////////////////////////////////

   // Fixed field positions for every format
   assign rs = instr[10:8];
   assign rt = instr[7:5];

   // No rs for the 000 group (halt, nop, misc)
   // and none for immediate jumps (001x0)
   assign rs_valid = (opcode[4:2] != 3'b000) &&
                     ({opcode[4:2], opcode[0]} != 4'b0010);

   // rt is read only by R-format ALU ops (1101x) and the 111 group
   assign rt_valid = (opcode[4:1] == 4'b1101) || (opcode[4:2] == 3'b111);

   ////////////////////////////////////////////////////////////////////////////
   // Class
   ////////////////////////////////////////////////////////////////////////////

   assign is_halt   = (opcode == op_halt);
   assign is_jump   = (opcode[4:2] == jump_class);
   assign is_branch = (opcode[4:2] == branch_class);

endmodule

// File: logic/instr_mem.sv
/*
   Instruction memory, 256 words of 16 bits
   Combinational read port for fetch, clocked write port for program load
*/
`timescale 1ns/1ps

module instr_mem import fetch_pkg::*; (
   input  logic               clk,
   // Read port, driven by the PC
   input  logic [imem_aw-1:0] addr,
   output logic [word_w-1:0]  rdata,
   // Load port, only used while the core sits in reset
   input  logic               we,
   input  logic [imem_aw-1:0] waddr,
   input  logic [word_w-1:0]  wdata
);

   // Word array
   logic [word_w-1:0] mem [0:(1 << imem_aw) - 1];

   ////////////////////////////////////////////////////////////////////////////
   // Read
   ////////////////////////////////////////////////////////////////////////////

   // Async read, the word is valid in the same cycle as the PC
   assign rdata = mem[addr];

   ////////////////////////////////////////////////////////////////////////////
   // Write
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   // Loads must not hit the word being fetched
   // Only exception is word 0 while the PC is parked at its reset value
   a_no_fetch_collision: assert property (
      @(posedge clk) (we && (waddr == addr)) |-> (addr == '0)
   ) else $error("instr_mem: load to word %0d collides with fetch", waddr);

endmodule

// File: logic/pc_unit.sv
/*
   Program counter
   Sequential +2 step, redirect load and hold
*/
`timescale 1ns/1ps

module pc_unit import fetch_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   // Redirect strobe and target from execute
   input  logic              pc_src,
   input  logic [word_w-1:0] jump_pc,
   // Hold request from fetch control
   input  logic              pc_hold,
   output logic [word_w-1:0] pc,
   output logic [word_w-1:0] pc_next_seq
);

   logic [word_w-1:0] pc_d;

   // Byte addressed, one 16-bit word per step
   assign pc_next_seq = pc + word_w'(2);

   // Next PC select
   // Fetch drops pc_hold on a redirect unless the stage has halted,
   // so checking the hold first keeps the halt freeze above pc_src
   always_comb begin
      if (pc_hold) begin
         pc_d = pc;
      end else if (pc_src) begin
         pc_d = jump_pc;
      end else begin
         pc_d = pc_next_seq;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // PC register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= '0;
      end else begin
         pc <= pc_d;
      end
   end

   // Redirect target is word aligned
   a_jump_aligned: assert property (
      @(posedge clk) disable iff (!rst_n) (pc_src && !pc_hold) |=> !pc[0]
   ) else $error("pc_unit: redirect to odd address %h", pc);

endmodule

// File: logic/raw_detector.sv
/*
   RAW hazard detector
   Shift history of in-flight destinations and the rs / rt compare
*/
`timescale 1ns/1ps

module raw_detector import fetch_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   // Sources of the fetched word
   input  logic [reg_w-1:0] rs,
   input  logic [reg_w-1:0] rt,
   input  logic             rs_valid,
   input  logic             rt_valid,
   // Destination accepted by the next stage this cycle
   input  logic [reg_w-1:0] dst,
   input  logic             dst_valid,
   output logic             raw
);

   // History of accepted destinations, newest in entry 0
   logic [reg_w-1:0] hist_dst [raw_depth];
   logic [raw_depth-1:0] hist_v;

   logic rs_hit;
   logic rt_hit;

   // Match against the live dst and every valid history entry
   function automatic logic dst_match(input logic [reg_w-1:0] src);
      logic hit;
      hit = dst_valid && (dst == src);
      for (int i = 0; i < raw_depth; i++) begin
         if (hist_v[i] && (hist_dst[i] == src)) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // History shift
   ////////////////////////////////////////////////////////////////////////////

   // Valid bits take dst_valid each cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hist_v <= '0;
      end else begin
         hist_v <= {hist_v[raw_depth-2:0], dst_valid};
      end
   end

   // Destination indices shift beside the valid bits
   always_ff @(posedge clk) begin
      hist_dst[0] <= dst;
      for (int i = 1; i < raw_depth; i++) begin
         hist_dst[i] <= hist_dst[i-1];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Compare
   ////////////////////////////////////////////////////////////////////////////

   // Sources only count when the classifier marks them valid
   always_comb begin
      rs_hit = rs_valid && dst_match(rs);
      rt_hit = rt_valid && dst_match(rt);
   end

   assign raw = rs_hit || rt_hit;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
   -f sources.f -o fetch_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log

grep -q "^RESULT: PASS$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: sources.f
logic/fetch_pkg.sv
logic/instr_mem.sv
logic/pc_unit.sv
logic/instr_classify.sv
logic/raw_detector.sv
logic/fetch.sv
logic/fetch_top.sv
dv/fetch_tb.sv
